// ==== arp_top.f ====
+incdir+hw
hw/arp_proto_pkg.sv
hw/arp_ctrl_pkg.sv
hw/arp_ifs.sv
hw/arp_cache.sv
hw/arp_responder.sv
hw/arp_resolver.sv
hw/arp_tx_mux.sv
hw/arp_top.sv
testbench/tb_clock_gen.sv
testbench/tb_arp_top.sv

// ==== hw/arp_cache.sv ====
// direct-mapped IP to MAC cache with query port, write port and clear
`timescale 1ns/1ps
`default_nettype none

`include "arp_settings.svh"

module arp_cache
    import arp_proto_pkg::*;
    import arp_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         clear_cache,
    input  logic         wr_valid,
    input  ip_t          wr_ip,
    input  mac_t         wr_mac,
    cache_query_if.cache query
);
    localparam int ENTRIES = 1 << `ARP_CACHE_ADDR_WIDTH;

    logic [ENTRIES-1:0] entry_valid;
    ip_t                tag_mem [ENTRIES];
    mac_t               mac_mem [ENTRIES];
    cache_index_t       wr_idx;
    cache_index_t       rd_idx;
    logic               rsp_valid_q;
    logic               rsp_error_q;
    mac_t               rsp_mac_q;

    assign wr_idx = wr_ip[`ARP_CACHE_ADDR_WIDTH-1:0];
    assign rd_idx = query.ip[`ARP_CACHE_ADDR_WIDTH-1:0];

    // clear drops every entry at once
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            entry_valid <= '0;
        end else if (wr_valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // newest sender replaces whatever sat in the slot
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            tag_mem[wr_idx] <= wr_ip;
            mac_mem[wr_idx] <= wr_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= query.req_valid;
        end
    end

    // tag mismatch or empty slot reads as a miss
    always_ff @(posedge clk) begin
        rsp_error_q <= !(entry_valid[rd_idx] && tag_mem[rd_idx] == query.ip);
        rsp_mac_q   <= mac_mem[rd_idx];
    end

    assign query.rsp_valid = rsp_valid_q;
    assign query.rsp_error = rsp_error_q;
    assign query.rsp_mac   = rsp_mac_q;

endmodule

`default_nettype wire

// ==== hw/arp_ctrl_pkg.sv ====
// resolver state encoding and cache index type
`default_nettype none

`include "arp_settings.svh"

package arp_ctrl_pkg;

    // lookup sequencing
    typedef enum logic [1:0] {
        IDLE,
        QUERY,
        WAIT_REPLY,
        RESPOND
    } resolver_state_e;

    // low IP bits select the cache entry
    typedef logic [`ARP_CACHE_ADDR_WIDTH-1:0] cache_index_t;

endpackage

`default_nettype wire

// ==== hw/arp_ifs.sv ====
// outgoing ARP frame interface and cache query interface with their modports
`timescale 1ns/1ps
`default_nettype none

interface arp_frame_if import arp_proto_pkg::*; ();
    logic      valid;
    logic      ready;
    mac_t      dest_mac;
    arp_oper_e oper;
    mac_t      tha;
    ip_t       tpa;

    // fields stay stable until valid meets ready
    modport source (output valid, dest_mac, oper, tha, tpa, input ready);
    modport sink (input valid, dest_mac, oper, tha, tpa, output ready);
endinterface

interface cache_query_if import arp_proto_pkg::*; ();
    // request side is held as a level
    logic req_valid;
    ip_t  ip;

    // answered one cycle after each requesting cycle
    logic rsp_valid;
    logic rsp_error;
    mac_t rsp_mac;

    modport requester (output req_valid, ip, input rsp_valid, rsp_error, rsp_mac);
    modport cache (input req_valid, ip, output rsp_valid, rsp_error, rsp_mac);
endinterface

`default_nettype wire

// ==== hw/arp_proto_pkg.sv ====
// MAC and IPv4 address types, ARP operation codes and the broadcast MAC
`default_nettype none

package arp_proto_pkg;

    // hardware address
    typedef logic [47:0] mac_t;

    // protocol address
    typedef logic [31:0] ip_t;

    // oper field as it appears on the wire
    typedef enum logic [15:0] {
        ARP_REQUEST   = 16'd1,
        ARP_REPLY     = 16'd2,
        INARP_REQUEST = 16'd8,
        INARP_REPLY   = 16'd9
    } arp_oper_e;

    // destination for requests and result for broadcast lookups
    localparam mac_t BROADCAST_MAC = 48'hffff_ffff_ffff;

endpackage

`default_nettype wire

// ==== hw/arp_resolver.sv ====
// lookup FSM with broadcast and subnet decisions, request retries and tick timer
`timescale 1ns/1ps
`default_nettype none

`include "arp_settings.svh"

module arp_resolver
    import arp_proto_pkg::*;
    import arp_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             lookup_valid,
    output logic             lookup_ready,
    input  ip_t              lookup_ip,
    output logic             resp_valid,
    input  logic             resp_ready,
    output logic             resp_error,
    output mac_t             resp_mac,
    input  ip_t              gateway_ip,
    input  ip_t              subnet_mask,
    cache_query_if.requester query,
    arp_frame_if.source      frame
);
    localparam int RETRY_W = $clog2(`ARP_RETRY_COUNT + 1);
    localparam int TIMER_W = $clog2(`ARP_RETRY_INTERVAL + `ARP_TIMEOUT + 1);
    localparam int TICK_W  = $clog2(`ARP_TICK_CYCLES + 1);

    resolver_state_e    state;
    ip_t                target_ip;
    logic               query_valid;
    logic               frame_valid;
    ip_t                frame_tpa;
    logic [RETRY_W-1:0] retries_left;
    logic [RETRY_W-1:0] frames_after;
    logic [TIMER_W-1:0] timer;
    logic [TICK_W-1:0]  tick_cnt;
    logic               tick;
    logic               accept;
    logic               limited_bcast;
    logic               in_subnet;
    logic               subnet_bcast;
    logic               frame_free;
    logic               busy;
    logic               lookup_hit;
    logic               give_up;
    logic               send_frame;

    assign accept        = lookup_valid && lookup_ready;
    assign limited_bcast = &lookup_ip;
    assign in_subnet     = ((lookup_ip ^ gateway_ip) & subnet_mask) == '0;
    // host bits all set inside our subnet
    assign subnet_bcast  = in_subnet && (&(lookup_ip | subnet_mask));

    assign frame_free = !frame_valid || frame.ready;
    assign busy       = state == QUERY || state == WAIT_REPLY;
    assign lookup_hit = busy && query.rsp_valid && !query.rsp_error;
    assign give_up    = state == WAIT_REPLY && !lookup_hit && timer == '0 &&
                        retries_left == '0;

    // first miss sends at once, later frames wait for the interval
    always_comb begin
        send_frame = 1'b0;
        if (state == QUERY) begin
            send_frame = query.rsp_valid && query.rsp_error && frame_free;
        end else if (state == WAIT_REPLY) begin
            send_frame = !lookup_hit && timer == '0 && retries_left != '0 && frame_free;
        end
    end

    assign frames_after = (state == QUERY) ? RETRY_W'(`ARP_RETRY_COUNT - 1)
                                           : retries_left - 1'b1;

    // prescaler restarts on each send so the first tick is a full one
    assign tick = tick_cnt == TICK_W'(`ARP_TICK_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (rst || send_frame || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // last frame is followed by the longer timeout
    always_ff @(posedge clk) begin
        if (rst) begin
            timer        <= '0;
            retries_left <= '0;
        end else if (send_frame) begin
            retries_left <= frames_after;
            timer        <= (frames_after != '0) ? TIMER_W'(`ARP_RETRY_INTERVAL)
                                                 : TIMER_W'(`ARP_TIMEOUT);
        end else if (tick && timer != '0) begin
            timer <= timer - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else if (send_frame) begin
            frame_valid <= 1'b1;
        end else if (frame.ready) begin
            frame_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            lookup_ready <= 1'b0;
            query_valid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    lookup_ready <= !accept;
                    if (accept && (limited_bcast || subnet_bcast)) begin
                        state <= RESPOND;
                    end else if (accept) begin
                        query_valid <= 1'b1;
                        state       <= QUERY;
                    end
                end
                QUERY, WAIT_REPLY: begin
                    // cache keeps answering while the query is held
                    if (lookup_hit || give_up) begin
                        query_valid <= 1'b0;
                        state       <= RESPOND;
                    end else if (send_frame) begin
                        state <= WAIT_REPLY;
                    end
                end
                RESPOND: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // off-subnet addresses resolve through the gateway
    always_ff @(posedge clk) begin
        if (accept) begin
            target_ip  <= in_subnet ? lookup_ip : gateway_ip;
            resp_mac   <= BROADCAST_MAC;
            resp_error <= 1'b0;
        end else if (lookup_hit) begin
            resp_mac   <= query.rsp_mac;
            resp_error <= 1'b0;
        end else if (give_up) begin
            resp_mac   <= '0;
            resp_error <= 1'b1;
        end
        if (send_frame) begin
            frame_tpa <= target_ip;
        end
    end

    assign resp_valid      = state == RESPOND;
    assign query.req_valid = query_valid;
    assign query.ip        = target_ip;
    assign frame.valid     = frame_valid;
    assign frame.dest_mac  = BROADCAST_MAC;
    assign frame.oper      = ARP_REQUEST;
    assign frame.tha       = '0;
    assign frame.tpa       = frame_tpa;

endmodule

`default_nettype wire

// ==== hw/arp_responder.sv ====
// ARP and InARP responder that also learns sender addresses into the cache
`timescale 1ns/1ps
`default_nettype none

module arp_responder import arp_proto_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_valid,
    output logic        rx_ready,
    input  mac_t        rx_src_mac,
    input  arp_oper_e   rx_oper,
    input  mac_t        rx_sha,
    input  ip_t         rx_spa,
    input  mac_t        rx_tha,
    input  ip_t         rx_tpa,
    input  mac_t        local_mac,
    input  ip_t         local_ip,
    output logic        wr_valid,
    output ip_t         wr_ip,
    output mac_t        wr_mac,
    arp_frame_if.source frame
);
    logic rx_enable;
    logic accept;
    logic reply_hit;
    logic reply_valid;

    // one idle cycle after reset before frames are taken
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_enable <= 1'b0;
        end else begin
            rx_enable <= 1'b1;
        end
    end

    // every frame needs a free reply slot, replying or not
    assign rx_ready = rx_enable && (!reply_valid || frame.ready);
    assign accept   = rx_valid && rx_ready;

    assign reply_hit = (rx_oper == ARP_REQUEST && rx_tpa == local_ip) ||
                       (rx_oper == INARP_REQUEST && rx_tha == local_mac);

    always_ff @(posedge clk) begin
        if (rst) begin
            reply_valid <= 1'b0;
            wr_valid    <= 1'b0;
        end else begin
            wr_valid <= accept;
            if (accept) begin
                reply_valid <= reply_hit;
            end else if (frame.ready) begin
                reply_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_ip          <= rx_spa;
            wr_mac         <= rx_sha;
            frame.dest_mac <= rx_src_mac;
            frame.oper     <= (rx_oper == INARP_REQUEST) ? INARP_REPLY : ARP_REPLY;
            frame.tha      <= rx_sha;
            frame.tpa      <= rx_spa;
        end
    end

    assign frame.valid = reply_valid;

endmodule

`default_nettype wire

// ==== hw/arp_settings.svh ====
// cache size, retry count, retry interval, timeout and tick length for the ARP block
`ifndef ARP_SETTINGS_SVH
`define ARP_SETTINGS_SVH

// log2 of the number of cache entries
`define ARP_CACHE_ADDR_WIDTH 4

// request frames sent per lookup
`define ARP_RETRY_COUNT 3

// ticks between request frames
`define ARP_RETRY_INTERVAL 4

// ticks waited after the last request before giving up
`define ARP_TIMEOUT 10

// clock cycles per tick
// kept short so simulation stays fast
`define ARP_TICK_CYCLES 8

`endif

// ==== hw/arp_top.sv ====
// ARP resolver and responder top level wiring cache, responder, resolver and tx mux
`timescale 1ns/1ps
`default_nettype none

module arp_top import arp_proto_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // parsed ARP frames in
    input  logic      rx_valid,
    output logic      rx_ready,
    input  mac_t      rx_src_mac,
    input  arp_oper_e rx_oper,
    input  mac_t      rx_sha,
    input  ip_t       rx_spa,
    input  mac_t      rx_tha,
    input  ip_t       rx_tpa,

    // ARP frames out, sender is always the local address
    output logic      tx_valid,
    input  logic      tx_ready,
    output mac_t      tx_dest_mac,
    output arp_oper_e tx_oper,
    output mac_t      tx_tha,
    output ip_t       tx_tpa,

    // address lookups
    input  logic      lookup_valid,
    output logic      lookup_ready,
    input  ip_t       lookup_ip,
    output logic      resp_valid,
    input  logic      resp_ready,
    output logic      resp_error,
    output mac_t      resp_mac,

    // configuration
    input  mac_t      local_mac,
    input  ip_t       local_ip,
    input  ip_t       gateway_ip,
    input  ip_t       subnet_mask,
    input  logic      clear_cache
);
    logic cache_wr_valid;
    ip_t  cache_wr_ip;
    mac_t cache_wr_mac;

    arp_frame_if   resp_frame ();
    arp_frame_if   res_frame ();
    cache_query_if cache_q ();

    arp_responder responder_i (
        .clk        (clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_src_mac (rx_src_mac),
        .rx_oper    (rx_oper),
        .rx_sha     (rx_sha),
        .rx_spa     (rx_spa),
        .rx_tha     (rx_tha),
        .rx_tpa     (rx_tpa),
        .local_mac  (local_mac),
        .local_ip   (local_ip),
        .wr_valid   (cache_wr_valid),
        .wr_ip      (cache_wr_ip),
        .wr_mac     (cache_wr_mac),
        .frame      (resp_frame.source)
    );

    arp_resolver resolver_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready),
        .lookup_ip    (lookup_ip),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_error   (resp_error),
        .resp_mac     (resp_mac),
        .gateway_ip   (gateway_ip),
        .subnet_mask  (subnet_mask),
        .query        (cache_q.requester),
        .frame        (res_frame.source)
    );

    arp_tx_mux tx_mux_i (
        .clk         (clk),
        .rst         (rst),
        .res_frame   (res_frame.sink),
        .resp_frame  (resp_frame.sink),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_dest_mac (tx_dest_mac),
        .tx_oper     (tx_oper),
        .tx_tha      (tx_tha),
        .tx_tpa      (tx_tpa)
    );

    arp_cache cache_i (
        .clk         (clk),
        .rst         (rst),
        .clear_cache (clear_cache),
        .wr_valid    (cache_wr_valid),
        .wr_ip       (cache_wr_ip),
        .wr_mac      (cache_wr_mac),
        .query       (cache_q.cache)
    );

endmodule

`default_nettype wire

// ==== hw/arp_tx_mux.sv ====
// single-slot outgoing frame register arbitrating resolver over responder
`timescale 1ns/1ps
`default_nettype none

module arp_tx_mux import arp_proto_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    arp_frame_if.sink res_frame,
    arp_frame_if.sink resp_frame,
    output logic      tx_valid,
    input  logic      tx_ready,
    output mac_t      tx_dest_mac,
    output arp_oper_e tx_oper,
    output mac_t      tx_tha,
    output ip_t       tx_tpa
);
    logic slot_free;
    logic take_res;
    logic take_resp;

    // slot can refill in the same cycle it drains
    assign slot_free = !tx_valid || tx_ready;

    // resolver has priority
    assign res_frame.ready  = slot_free;
    assign resp_frame.ready = slot_free && !res_frame.valid;

    assign take_res  = res_frame.valid && res_frame.ready;
    assign take_resp = resp_frame.valid && resp_frame.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (slot_free) begin
            tx_valid <= take_res || take_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (take_res) begin
            tx_dest_mac <= res_frame.dest_mac;
            tx_oper     <= res_frame.oper;
            tx_tha      <= res_frame.tha;
            tx_tpa      <= res_frame.tpa;
        end else if (take_resp) begin
            tx_dest_mac <= resp_frame.dest_mac;
            tx_oper     <= resp_frame.oper;
            tx_tha      <= resp_frame.tha;
            tx_tpa      <= resp_frame.tpa;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the ARP testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f arp_top.f --top-module tb_arp_top -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_arp_top 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== testbench/tb_arp_top.sv ====
// ARP testbench with stimulus table, row runner, tx frame monitor, check task and timeouts
`timescale 1ns/1ps
`default_nettype none

`include "arp_settings.svh"

module tb_arp_top import arp_proto_pkg::*; ();

    localparam logic [1:0] ACT_FRAME  = 2'd0;
    localparam logic [1:0] ACT_LOOKUP = 2'd1;
    localparam logic [1:0] ACT_CLEAR  = 2'd2;

    localparam mac_t LOCAL_MAC = 48'h02_00_00_00_00_01;
    localparam ip_t  LOCAL_IP  = 32'h0a_00_00_01;
    localparam ip_t  GW_IP     = 32'h0a_00_00_fe;
    localparam ip_t  MASK      = 32'hff_ff_ff_00;

    // peers with low nibbles kept apart so cache slots never collide
    localparam mac_t A_MAC  = 48'h0a_11_22_33_44_55;
    localparam mac_t A2_MAC = 48'h0a_11_22_33_44_56;
    localparam ip_t  A_IP   = 32'h0a_00_00_14;
    localparam mac_t B_MAC  = 48'h0a_66_77_88_99_aa;
    localparam ip_t  B_IP   = 32'h0a_00_00_23;
    localparam mac_t C_MAC  = 48'h0a_bb_cc_dd_ee_01;
    localparam ip_t  C_IP   = 32'h0a_00_00_29;
    localparam mac_t D_MAC  = 48'h0a_d0_d0_d0_d0_46;
    localparam ip_t  D_IP   = 32'h0a_00_00_46;
    localparam mac_t GW_MAC = 48'h0a_fe_fe_fe_fe_fe;
    localparam ip_t  FAR_IP = 32'hc0_a8_01_05;
    localparam ip_t  MUTE_IP = 32'h0a_00_00_4d;

    localparam int HANDSHAKE_LIMIT = 64;
    localparam int FRAME_LIMIT     = 128;
    localparam int RESPONSE_LIMIT  = 2 * `ARP_TICK_CYCLES *
        (`ARP_RETRY_COUNT * `ARP_RETRY_INTERVAL + `ARP_TIMEOUT + 4);
    localparam int SETTLE_CYCLES   = 4;

    typedef struct packed {
        logic [1:0]  act;
        ip_t         lookup_ip;
        logic        answer;
        mac_t        src_mac;
        arp_oper_e   oper;
        mac_t        sha;
        ip_t         spa;
        mac_t        tha;
        ip_t         tpa;
        logic [3:0]  exp_frames;
        mac_t        exp_dest;
        logic [15:0] exp_oper;
        mac_t        exp_tha;
        ip_t         exp_tpa;
        mac_t        exp_mac;
        logic        exp_err;
    } row_t;

    logic      clk;
    logic      rst;
    logic      rx_valid;
    logic      rx_ready;
    mac_t      rx_src_mac;
    arp_oper_e rx_oper;
    mac_t      rx_sha;
    ip_t       rx_spa;
    mac_t      rx_tha;
    ip_t       rx_tpa;
    logic      tx_valid;
    logic      tx_ready;
    mac_t      tx_dest_mac;
    arp_oper_e tx_oper;
    mac_t      tx_tha;
    ip_t       tx_tpa;
    logic      lookup_valid;
    logic      lookup_ready;
    ip_t       lookup_ip;
    logic      resp_valid;
    logic      resp_ready;
    logic      resp_error;
    mac_t      resp_mac;
    logic      clear_cache;

    row_t        rows[$];
    int unsigned frame_count = 0;
    mac_t        last_dest_mac;
    logic [15:0] last_oper;
    mac_t        last_tha;
    ip_t         last_tpa;

    tb_clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    arp_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_src_mac   (rx_src_mac),
        .rx_oper      (rx_oper),
        .rx_sha       (rx_sha),
        .rx_spa       (rx_spa),
        .rx_tha       (rx_tha),
        .rx_tpa       (rx_tpa),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_dest_mac  (tx_dest_mac),
        .tx_oper      (tx_oper),
        .tx_tha       (tx_tha),
        .tx_tpa       (tx_tpa),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready),
        .lookup_ip    (lookup_ip),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_error   (resp_error),
        .resp_mac     (resp_mac),
        .local_mac    (LOCAL_MAC),
        .local_ip     (LOCAL_IP),
        .gateway_ip   (GW_IP),
        .subnet_mask  (MASK),
        .clear_cache  (clear_cache)
    );

    // tx_ready stays high, so each negedge with tx_valid is one frame
    always @(negedge clk) begin
        if (tx_valid && tx_ready) begin
            frame_count   <= frame_count + 1;
            last_dest_mac <= tx_dest_mac;
            last_oper     <= tx_oper;
            last_tha      <= tx_tha;
            last_tpa      <= tx_tpa;
        end
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    // link-layer source of an injected frame, distinct from the ARP sender MAC
    function automatic mac_t relay_mac(input mac_t sender);
        return {8'h02, sender[39:0]};
    endfunction

    // reply expected to go back to the link-layer source of the frame
    task automatic frame_row(input arp_oper_e oper, input mac_t mac, input ip_t ip,
                             input mac_t tha, input ip_t tpa, input logic [3:0] frames,
                             input logic [15:0] exp_oper);
        row_t r;
        r = '0;
        r.act        = ACT_FRAME;
        r.src_mac    = relay_mac(mac);
        r.oper       = oper;
        r.sha        = mac;
        r.spa        = ip;
        r.tha        = tha;
        r.tpa        = tpa;
        r.exp_frames = frames;
        r.exp_dest   = r.src_mac;
        r.exp_oper   = exp_oper;
        r.exp_tha    = mac;
        r.exp_tpa    = ip;
        rows.push_back(r);
    endtask

    // answer, when set, is an ARP reply from ans_mac and ans_ip after the first request
    task automatic lookup_row(input ip_t ip, input logic answer, input mac_t ans_mac,
                              input ip_t ans_ip, input logic [3:0] frames, input ip_t req_tpa,
                              input mac_t exp_mac, input logic exp_err);
        row_t r;
        r = '0;
        r.act        = ACT_LOOKUP;
        r.lookup_ip  = ip;
        r.answer     = answer;
        r.src_mac    = relay_mac(ans_mac);
        r.oper       = ARP_REPLY;
        r.sha        = ans_mac;
        r.spa        = ans_ip;
        r.tha        = LOCAL_MAC;
        r.tpa        = LOCAL_IP;
        r.exp_frames = frames;
        r.exp_dest   = BROADCAST_MAC;
        r.exp_oper   = 16'd1;
        r.exp_tha    = '0;
        r.exp_tpa    = req_tpa;
        r.exp_mac    = exp_mac;
        r.exp_err    = exp_err;
        rows.push_back(r);
    endtask

    task automatic clear_row();
        row_t r;
        r = '0;
        r.act = ACT_CLEAR;
        rows.push_back(r);
    endtask

    task automatic build_table();
        lookup_row(32'hff_ff_ff_ff, 1'b0, '0, '0, 4'd0, '0, BROADCAST_MAC, 1'b0);
        lookup_row(32'h0a_00_00_ff, 1'b0, '0, '0, 4'd0, '0, BROADCAST_MAC, 1'b0);
        frame_row(ARP_REQUEST, A_MAC, A_IP, '0, LOCAL_IP, 4'd1, 16'd2);
        lookup_row(A_IP, 1'b0, '0, '0, 4'd0, '0, A_MAC, 1'b0);
        frame_row(INARP_REQUEST, B_MAC, B_IP, LOCAL_MAC, '0, 4'd1, 16'd9);
        frame_row(INARP_REQUEST, C_MAC, C_IP, 48'h0a_00_00_00_00_99, '0, 4'd0, 16'd0);
        lookup_row(C_IP, 1'b0, '0, '0, 4'd0, '0, C_MAC, 1'b0);
        lookup_row(D_IP, 1'b1, D_MAC, D_IP, 4'd1, D_IP, D_MAC, 1'b0);
        lookup_row(FAR_IP, 1'b1, GW_MAC, GW_IP, 4'd1, GW_IP, GW_MAC, 1'b0);
        lookup_row(MUTE_IP, 1'b0, '0, '0, 4'(`ARP_RETRY_COUNT), MUTE_IP, '0, 1'b1);
        clear_row();
        // A is known again only through the fresh reply
        lookup_row(A_IP, 1'b1, A2_MAC, A_IP, 4'd1, A_IP, A2_MAC, 1'b0);
    endtask

    task automatic drive_frame(input row_t r);
        int waited;
        waited = 0;
        rx_valid   = 1'b1;
        rx_src_mac = r.src_mac;
        rx_oper    = r.oper;
        rx_sha     = r.sha;
        rx_spa     = r.spa;
        rx_tha     = r.tha;
        rx_tpa     = r.tpa;
        while (!rx_ready) begin
            @(negedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_timeout("rx_ready on an input frame");
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic start_lookup(input ip_t ip);
        int waited;
        waited = 0;
        lookup_valid = 1'b1;
        lookup_ip    = ip;
        while (!lookup_ready) begin
            @(negedge clk);
            waited++;
            if (waited > HANDSHAKE_LIMIT) report_timeout("lookup_ready");
        end
        @(negedge clk);
        lookup_valid = 1'b0;
    endtask

    task automatic wait_frames(input int unsigned target);
        int waited;
        waited = 0;
        while (frame_count < target) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME_LIMIT) report_timeout("an outgoing tx frame");
        end
    endtask

    task automatic wait_response();
        int waited;
        waited = 0;
        while (!resp_valid) begin
            @(negedge clk);
            waited++;
            if (waited > RESPONSE_LIMIT) report_timeout("resp_valid on a lookup");
        end
    endtask

    task automatic run_row(input int idx, input row_t r);
        int unsigned start;
        mac_t        got_mac;
        logic        got_err;
        start   = frame_count;
        got_mac = '0;
        got_err = 1'b0;
        case (r.act)
            ACT_FRAME: begin
                drive_frame(r);
                wait_frames(start + r.exp_frames);
            end
            ACT_LOOKUP: begin
                start_lookup(r.lookup_ip);
                if (r.answer) begin
                    wait_frames(start + 1);
                    drive_frame(r);
                end
                wait_response();
                got_mac = resp_mac;
                got_err = resp_error;
            end
            default: begin
                clear_cache = 1'b1;
                @(negedge clk);
                clear_cache = 1'b0;
            end
        endcase
        // replies land two cycles after acceptance, so a short settle catches strays
        repeat (SETTLE_CYCLES) @(negedge clk);
        check_value("tx frame count", frame_count - start, r.exp_frames);
        if (r.exp_frames != 0) begin
            check_value("tx_dest_mac", last_dest_mac, r.exp_dest);
            check_value("tx_oper", last_oper, r.exp_oper);
            check_value("tx_tha", last_tha, r.exp_tha);
            check_value("tx_tpa", last_tpa, r.exp_tpa);
        end
        if (r.act == ACT_LOOKUP) begin
            check_value("resp_error", got_err, r.exp_err);
            if (!r.exp_err) check_value("resp_mac", got_mac, r.exp_mac);
        end
        $display("row %0d done", idx);
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst) begin
            @(posedge clk);
            waited++;
            if (waited > 32) report_timeout("reset release");
        end
    endtask

    initial begin
        rx_valid     = 1'b0;
        rx_src_mac   = '0;
        rx_oper      = ARP_REQUEST;
        rx_sha       = '0;
        rx_spa       = '0;
        rx_tha       = '0;
        rx_tpa       = '0;
        tx_ready     = 1'b1;
        lookup_valid = 1'b0;
        lookup_ip    = '0;
        resp_ready   = 1'b1;
        clear_cache  = 1'b0;
        build_table();

        // outputs parked low while reset is held
        @(posedge clk);
        @(negedge clk);
        check_value("rx_ready", rx_ready, 1'b0);
        check_value("tx_valid", tx_valid, 1'b0);
        check_value("lookup_ready", lookup_ready, 1'b0);
        check_value("resp_valid", resp_valid, 1'b0);

        wait_reset_release();
        @(negedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i, rows[i]);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// testbench clock with 4 ns period and 8-cycle synchronous reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release on a falling edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire
